/* verilog/e31x_ctrl_pkg.sv */
// Shared definitions for the E31x front-end control block
//   Bus and field types
//   Register byte offsets
//   Status word and LED word bit positions
package e31x_ctrl_pkg;

  // AXI4-Lite bus widths
  typedef logic [13:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [3:0]  reg_strb_t;
  typedef logic [1:0]  axi_resp_t;

  // Per-channel front-end control word
  //   [2:0]  TX band select
  //   [5:3]  RX band select
  //   [7:6]  RX B band select
  //   [9:8]  RX C band select
  //   [10]   TX enable A, [11] TX enable B
  //   [12]   TX/RX antenna V2, [13] TX/RX antenna V1
  //   [14]   RX antenna V2, [15] RX antenna V1
  typedef logic [15:0] db_gpio_t;

  // Per-channel LEDs
  // [0] TX/RX receive, [1] TX/RX transmit, [2] RX receive
  typedef logic [2:0] led_t;

  typedef logic [2:0] bandsel_wide_t;
  typedef logic [1:0] bandsel_narrow_t;

  // {PLL lock, 10 MHz present, PPS present, reference lock}
  typedef logic [3:0] tcxo_status_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  // Read only
  localparam reg_addr_t REG_DB_STATUS = 14'h0000;
  // Low 16 bits used
  localparam reg_addr_t REG_DB_GPIO0  = 14'h0004;
  localparam reg_addr_t REG_DB_GPIO1  = 14'h0008;
  localparam reg_addr_t REG_LEDS      = 14'h000C;

  // Status word layout, everything else reads 0
  localparam int STAT_RX_LOCK_BIT = 8;
  localparam int STAT_TX_LOCK_BIT = 9;
  localparam int STAT_TCXO_LSB    = 10;

  // LED word layout
  localparam int LED0_LSB = 0;
  localparam int LED1_LSB = 4;

  localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

/* verilog/axil_ctrl_regs.sv */
`timescale 1ns/1ps
// AXI4-Lite register slave
//   GPIO words for both channels and the LED word, byte strobes honored
//   Read-only daughterboard status word
//   One outstanding write and one outstanding read
module axil_ctrl_regs (
  input  logic                          bus_clk,
  input  logic                          bus_rst,
  input  e31x_ctrl_pkg::reg_addr_t      s_axi_awaddr,
  input  logic                          s_axi_awvalid,
  output logic                          s_axi_awready,
  input  e31x_ctrl_pkg::reg_data_t      s_axi_wdata,
  input  e31x_ctrl_pkg::reg_strb_t      s_axi_wstrb,
  input  logic                          s_axi_wvalid,
  output logic                          s_axi_wready,
  output e31x_ctrl_pkg::axi_resp_t      s_axi_bresp,
  output logic                          s_axi_bvalid,
  input  logic                          s_axi_bready,
  input  e31x_ctrl_pkg::reg_addr_t      s_axi_araddr,
  input  logic                          s_axi_arvalid,
  output logic                          s_axi_arready,
  output e31x_ctrl_pkg::reg_data_t      s_axi_rdata,
  output e31x_ctrl_pkg::axi_resp_t      s_axi_rresp,
  output logic                          s_axi_rvalid,
  input  logic                          s_axi_rready,
  input  e31x_ctrl_pkg::tcxo_status_t   tcxo_status_s,
  input  logic                          tx_lock_s,
  input  logic                          rx_lock_s,
  output e31x_ctrl_pkg::db_gpio_t       db_gpio0,
  output e31x_ctrl_pkg::db_gpio_t       db_gpio1,
  output e31x_ctrl_pkg::led_t           led0,
  output e31x_ctrl_pkg::led_t           led1
);
  import e31x_ctrl_pkg::*;

  typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
  typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

  wr_state_t wr_state;
  rd_state_t rd_state;
  logic      wr_fire;
  logic      rd_fire;
  reg_addr_t wr_word;
  reg_addr_t rd_word;
  reg_data_t status_word;
  reg_data_t rd_mux;

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  // Address and data taken together, blocked while bvalid is up
  assign wr_fire = s_axi_awvalid && s_axi_wvalid && (wr_state == WR_IDLE);
  assign rd_fire = s_axi_arvalid && (rd_state == RD_IDLE);

  assign s_axi_awready = wr_fire;
  assign s_axi_wready  = wr_fire;
  assign s_axi_arready = rd_fire;
  assign s_axi_bvalid  = (wr_state == WR_RESP);
  assign s_axi_rvalid  = (rd_state == RD_RESP);
  // Unmapped and read-only offsets still answer OKAY
  assign s_axi_bresp   = RESP_OKAY;
  assign s_axi_rresp   = RESP_OKAY;

  // Word aligned offsets
  assign wr_word = {s_axi_awaddr[13:2], 2'b00};
  assign rd_word = {s_axi_araddr[13:2], 2'b00};

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (wr_fire) wr_state <= WR_RESP;
        WR_RESP: if (s_axi_bready) wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (rd_fire) rd_state <= RD_RESP;
        RD_RESP: if (s_axi_rready) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      db_gpio0 <= '0;
      db_gpio1 <= '0;
      led0     <= '0;
      led1     <= '0;
    end else if (wr_fire) begin
      case (wr_word)
        REG_DB_GPIO0: begin
          if (s_axi_wstrb[0]) db_gpio0[7:0]  <= s_axi_wdata[7:0];
          if (s_axi_wstrb[1]) db_gpio0[15:8] <= s_axi_wdata[15:8];
        end
        REG_DB_GPIO1: begin
          if (s_axi_wstrb[0]) db_gpio1[7:0]  <= s_axi_wdata[7:0];
          if (s_axi_wstrb[1]) db_gpio1[15:8] <= s_axi_wdata[15:8];
        end
        // Both LED fields sit in byte 0
        REG_LEDS: begin
          if (s_axi_wstrb[0]) begin
            led0 <= s_axi_wdata[LED0_LSB +: $bits(led_t)];
            led1 <= s_axi_wdata[LED1_LSB +: $bits(led_t)];
          end
        end
        // Status word and holes in the map drop the data
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  always_comb begin
    status_word = '0;
    status_word[STAT_TCXO_LSB +: $bits(tcxo_status_t)] = tcxo_status_s;
    status_word[STAT_TX_LOCK_BIT] = tx_lock_s;
    status_word[STAT_RX_LOCK_BIT] = rx_lock_s;
  end

  always_comb begin
    rd_mux = '0;
    case (rd_word)
      REG_DB_STATUS: rd_mux = status_word;
      REG_DB_GPIO0:  rd_mux[15:0] = db_gpio0;
      REG_DB_GPIO1:  rd_mux[15:0] = db_gpio1;
      REG_LEDS: begin
        rd_mux[LED0_LSB +: $bits(led_t)] = led0;
        rd_mux[LED1_LSB +: $bits(led_t)] = led1;
      end
      default: rd_mux = '0;
    endcase
  end

  // Captured with arready, held while rvalid waits
  always_ff @(posedge bus_clk) begin
    if (rd_fire) s_axi_rdata <= rd_mux;
  end

  // Response stays put until the master takes it
  a_b_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));

  a_r_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

/* verilog/status_sync.sv */
`timescale 1ns/1ps
// Status resync onto bus_clk
//   Two-flop sync for reference status and PLL locks
//   Three-flop PPS copy for the time keeping GPIO
module status_sync (
  input  logic                          bus_clk,
  input  logic                          bus_rst,
  input  e31x_ctrl_pkg::tcxo_status_t   tcxo_status,
  input  logic                          tx_pll_lock,
  input  logic                          rx_pll_lock,
  input  logic                          gps_pps,
  output e31x_ctrl_pkg::tcxo_status_t   tcxo_status_s,
  output logic                          tx_lock_s,
  output logic                          rx_lock_s,
  output logic                          pps_gpio
);
  import e31x_ctrl_pkg::*;

  localparam int SYNC_W = $bits(tcxo_status_t) + 2;

  logic [SYNC_W-1:0] st_meta;
  logic [SYNC_W-1:0] st_sync;
  logic [2:0]        pps_dly;

  // Inputs come from other clock domains
  always_ff @(posedge bus_clk) begin
    st_meta <= {tcxo_status, tx_pll_lock, rx_pll_lock};
    st_sync <= st_meta;
  end

  assign {tcxo_status_s, tx_lock_s, rx_lock_s} = st_sync;

  // PPS delay line
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      pps_dly <= '0;
    end else begin
      pps_dly <= {pps_dly[1:0], gps_pps};
    end
  end

  assign pps_gpio = pps_dly[2];

endmodule

/* verilog/button_irq.sv */
`timescale 1ns/1ps
// Power switch interrupts
//   Press and release edge detect on the active-low debounced switch
//   Each edge stretched to IRQ_STRETCH cycles
module button_irq #(
  parameter int IRQ_STRETCH = 8
) (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic onswitch_db,
  output logic press_irq,
  output logic release_irq
);

  logic [1:0]             sw_hist;
  // Marks history slots filled since reset
  logic [1:0]             hist_vld;
  logic                   press_edge;
  logic                   release_edge;
  logic [IRQ_STRETCH-1:0] press_sr;
  logic [IRQ_STRETCH-1:0] release_sr;

  // Low now after two high samples is a press
  assign press_edge   = hist_vld[1] && !onswitch_db && sw_hist[0] && sw_hist[1];
  // Mirror case, the reset lows in the history do not count
  assign release_edge = hist_vld[1] && onswitch_db && !sw_hist[0] && !sw_hist[1];

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      sw_hist    <= 2'b00;
      hist_vld   <= 2'b00;
      press_sr   <= '0;
      release_sr <= '0;
    end else begin
      sw_hist    <= {sw_hist[0], onswitch_db};
      hist_vld   <= {hist_vld[0], 1'b1};
      press_sr   <= {press_sr[IRQ_STRETCH-2:0], press_edge};
      release_sr <= {release_sr[IRQ_STRETCH-2:0], release_edge};
    end
  end

  // Stretched so the interrupt is not missed
  assign press_irq   = |press_sr;
  assign release_irq = |release_sr;

  a_irq_excl: assert property (@(posedge bus_clk) disable iff (bus_rst)
    !($rose(press_irq) && $rose(release_irq)));

endmodule

/* verilog/fe_pin_map.sv */
`timescale 1ns/1ps
// Front-end pin mapping
//   Register channel 1 to channel-1 pins, register channel 0 to channel-2 pins
//   TX band select shared by both channels
//   LED words follow the same swap
module fe_pin_map (
  input  e31x_ctrl_pkg::db_gpio_t          db_gpio0,
  input  e31x_ctrl_pkg::db_gpio_t          db_gpio1,
  input  e31x_ctrl_pkg::led_t              led0,
  input  e31x_ctrl_pkg::led_t              led1,
  output e31x_ctrl_pkg::bandsel_wide_t     tx_bandsel,
  output e31x_ctrl_pkg::bandsel_wide_t     rx1_bandsel,
  output e31x_ctrl_pkg::bandsel_wide_t     rx2_bandsel,
  output e31x_ctrl_pkg::bandsel_narrow_t   rx1b_bandsel,
  output e31x_ctrl_pkg::bandsel_narrow_t   rx1c_bandsel,
  output e31x_ctrl_pkg::bandsel_narrow_t   rx2b_bandsel,
  output e31x_ctrl_pkg::bandsel_narrow_t   rx2c_bandsel,
  output logic                             tx_enable1a,
  output logic                             tx_enable1b,
  output logic                             tx_enable2a,
  output logic                             tx_enable2b,
  output logic                             vctxrx1_v1,
  output logic                             vctxrx1_v2,
  output logic                             vctxrx2_v1,
  output logic                             vctxrx2_v2,
  output logic                             vcrx1_v1,
  output logic                             vcrx1_v2,
  output logic                             vcrx2_v1,
  output logic                             vcrx2_v2,
  output logic                             led_txrx1_tx,
  output logic                             led_txrx1_rx,
  output logic                             led_rx1_rx,
  output logic                             led_txrx2_tx,
  output logic                             led_txrx2_rx,
  output logic                             led_rx2_rx
);
  import e31x_ctrl_pkg::*;

  bandsel_wide_t tx1_bandsel;
  bandsel_wide_t tx2_bandsel;

  // Channel-1 pins from register channel 1, MSB first
  assign {vcrx1_v1, vcrx1_v2, vctxrx1_v1, vctxrx1_v2,
          tx_enable1b, tx_enable1a,
          rx1c_bandsel, rx1b_bandsel, rx1_bandsel,
          tx1_bandsel} = db_gpio1;

  // Channel-2 pins from register channel 0
  assign {vcrx2_v1, vcrx2_v2, vctxrx2_v1, vctxrx2_v2,
          tx_enable2b, tx_enable2a,
          rx2c_bandsel, rx2b_bandsel, rx2_bandsel,
          tx2_bandsel} = db_gpio0;

  // Both channels tune together
  // OR lets software drive either channel alone
  assign tx_bandsel = tx1_bandsel | tx2_bandsel;

  // LEDs, {RX rx, TX/RX tx, TX/RX rx}
  assign {led_rx1_rx, led_txrx1_tx, led_txrx1_rx} = led1;
  assign {led_rx2_rx, led_txrx2_tx, led_txrx2_rx} = led0;

endmodule

/* verilog/e31x_ctrl_top.sv */
`timescale 1ns/1ps
// E31x front-end control top level
//   AXI4-Lite register slave
//   Status and PPS resync
//   Power button interrupts
//   Front-end pin mapping
module e31x_ctrl_top #(
  parameter int IRQ_STRETCH = 8
) (
  input  logic                             bus_clk,
  input  logic                             bus_rst,
  // AXI4-Lite slave
  input  e31x_ctrl_pkg::reg_addr_t         s_axi_awaddr,
  input  logic                             s_axi_awvalid,
  output logic                             s_axi_awready,
  input  e31x_ctrl_pkg::reg_data_t         s_axi_wdata,
  input  e31x_ctrl_pkg::reg_strb_t         s_axi_wstrb,
  input  logic                             s_axi_wvalid,
  output logic                             s_axi_wready,
  output e31x_ctrl_pkg::axi_resp_t         s_axi_bresp,
  output logic                             s_axi_bvalid,
  input  logic                             s_axi_bready,
  input  e31x_ctrl_pkg::reg_addr_t         s_axi_araddr,
  input  logic                             s_axi_arvalid,
  output logic                             s_axi_arready,
  output e31x_ctrl_pkg::reg_data_t         s_axi_rdata,
  output e31x_ctrl_pkg::axi_resp_t         s_axi_rresp,
  output logic                             s_axi_rvalid,
  input  logic                             s_axi_rready,
  // Board inputs
  input  logic                             onswitch_db,
  input  logic                             gps_pps,
  input  e31x_ctrl_pkg::tcxo_status_t      tcxo_status,
  input  logic                             tx_pll_lock,
  input  logic                             rx_pll_lock,
  // Interrupts and PPS copy
  output logic                             press_irq,
  output logic                             release_irq,
  output logic                             pps_gpio,
  // Band selects
  output e31x_ctrl_pkg::bandsel_wide_t     tx_bandsel,
  output e31x_ctrl_pkg::bandsel_wide_t     rx1_bandsel,
  output e31x_ctrl_pkg::bandsel_wide_t     rx2_bandsel,
  output e31x_ctrl_pkg::bandsel_narrow_t   rx1b_bandsel,
  output e31x_ctrl_pkg::bandsel_narrow_t   rx1c_bandsel,
  output e31x_ctrl_pkg::bandsel_narrow_t   rx2b_bandsel,
  output e31x_ctrl_pkg::bandsel_narrow_t   rx2c_bandsel,
  // Enables
  output logic                             tx_enable1a,
  output logic                             tx_enable1b,
  output logic                             tx_enable2a,
  output logic                             tx_enable2b,
  // Antenna selects
  output logic                             vctxrx1_v1,
  output logic                             vctxrx1_v2,
  output logic                             vctxrx2_v1,
  output logic                             vctxrx2_v2,
  output logic                             vcrx1_v1,
  output logic                             vcrx1_v2,
  output logic                             vcrx2_v1,
  output logic                             vcrx2_v2,
  // LEDs
  output logic                             led_txrx1_tx,
  output logic                             led_txrx1_rx,
  output logic                             led_rx1_rx,
  output logic                             led_txrx2_tx,
  output logic                             led_txrx2_rx,
  output logic                             led_rx2_rx
);
  import e31x_ctrl_pkg::*;

  // Register words to the pin mapper
  db_gpio_t     db_gpio0;
  db_gpio_t     db_gpio1;
  led_t         led0;
  led_t         led1;
  // Resynchronized status
  tcxo_status_t tcxo_status_s;
  logic         tx_lock_s;
  logic         rx_lock_s;

  axil_ctrl_regs u_regs (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .tcxo_status_s (tcxo_status_s),
    .tx_lock_s     (tx_lock_s),
    .rx_lock_s     (rx_lock_s),
    .db_gpio0      (db_gpio0),
    .db_gpio1      (db_gpio1),
    .led0          (led0),
    .led1          (led1)
  );

  status_sync u_status_sync (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .tcxo_status   (tcxo_status),
    .tx_pll_lock   (tx_pll_lock),
    .rx_pll_lock   (rx_pll_lock),
    .gps_pps       (gps_pps),
    .tcxo_status_s (tcxo_status_s),
    .tx_lock_s     (tx_lock_s),
    .rx_lock_s     (rx_lock_s),
    .pps_gpio      (pps_gpio)
  );

  button_irq #(
    .IRQ_STRETCH (IRQ_STRETCH)
  ) u_button_irq (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch_db (onswitch_db),
    .press_irq   (press_irq),
    .release_irq (release_irq)
  );

  fe_pin_map u_pin_map (
    .db_gpio0     (db_gpio0),
    .db_gpio1     (db_gpio1),
    .led0         (led0),
    .led1         (led1),
    .tx_bandsel   (tx_bandsel),
    .rx1_bandsel  (rx1_bandsel),
    .rx2_bandsel  (rx2_bandsel),
    .rx1b_bandsel (rx1b_bandsel),
    .rx1c_bandsel (rx1c_bandsel),
    .rx2b_bandsel (rx2b_bandsel),
    .rx2c_bandsel (rx2c_bandsel),
    .tx_enable1a  (tx_enable1a),
    .tx_enable1b  (tx_enable1b),
    .tx_enable2a  (tx_enable2a),
    .tx_enable2b  (tx_enable2b),
    .vctxrx1_v1   (vctxrx1_v1),
    .vctxrx1_v2   (vctxrx1_v2),
    .vctxrx2_v1   (vctxrx2_v1),
    .vctxrx2_v2   (vctxrx2_v2),
    .vcrx1_v1     (vcrx1_v1),
    .vcrx1_v2     (vcrx1_v2),
    .vcrx2_v1     (vcrx2_v1),
    .vcrx2_v2     (vcrx2_v2),
    .led_txrx1_tx (led_txrx1_tx),
    .led_txrx1_rx (led_txrx1_rx),
    .led_rx1_rx   (led_rx1_rx),
    .led_txrx2_tx (led_txrx2_tx),
    .led_txrx2_rx (led_txrx2_rx),
    .led_rx2_rx   (led_rx2_rx)
  );

endmodule

/* tb/axil_bfm_tasks.svh */
// AXI4-Lite master tasks for the register slave
//   Write address and data phase, write response phase
//   Combined write and single read
// Every wait is bounded by AXI_TIMEOUT cycles
`ifndef AXIL_BFM_TASKS_SVH
`define AXIL_BFM_TASKS_SVH

// Drives address and data together and returns on the falling edge after acceptance
task automatic write_issue(input reg_addr_t addr, input reg_data_t data,
                           input reg_strb_t strb);
  int cnt;
  @(negedge bus_clk);
  s_axi_awaddr  = addr;
  s_axi_wdata   = data;
  s_axi_wstrb   = strb;
  s_axi_awvalid = 1'b1;
  s_axi_wvalid  = 1'b1;
  cnt = 0;
  #1;
  while (!(s_axi_awready && s_axi_wready) && cnt < AXI_TIMEOUT) begin
    @(negedge bus_clk);
    #1;
    cnt++;
  end
  if (!(s_axi_awready && s_axi_wready)) begin
    $display("Timeout: write to 0x%0h never saw awready and wready together", addr);
    errors++;
  end else begin
    @(posedge bus_clk);
  end
  @(negedge bus_clk);
  s_axi_awvalid = 1'b0;
  s_axi_wvalid  = 1'b0;
endtask

// Waits for bvalid and takes it with bready already high
task automatic write_resp(output axi_resp_t resp);
  int cnt;
  cnt = 0;
  while (!s_axi_bvalid && cnt < AXI_TIMEOUT) begin
    @(negedge bus_clk);
    cnt++;
  end
  resp = s_axi_bresp;
  if (!s_axi_bvalid) begin
    $display("Timeout: write response never arrived");
    errors++;
  end
  @(posedge bus_clk);
  @(negedge bus_clk);
endtask

task automatic axil_write(input reg_addr_t addr, input reg_data_t data,
                          input reg_strb_t strb, output axi_resp_t resp);
  write_issue(addr, data, strb);
  write_resp(resp);
endtask

task automatic axil_read(input reg_addr_t addr, output reg_data_t data,
                         output axi_resp_t resp);
  int cnt;
  @(negedge bus_clk);
  s_axi_araddr  = addr;
  s_axi_arvalid = 1'b1;
  cnt = 0;
  #1;
  while (!s_axi_arready && cnt < AXI_TIMEOUT) begin
    @(negedge bus_clk);
    #1;
    cnt++;
  end
  if (!s_axi_arready) begin
    $display("Timeout: read of 0x%0h was never accepted", addr);
    errors++;
  end else begin
    @(posedge bus_clk);
  end
  @(negedge bus_clk);
  s_axi_arvalid = 1'b0;
  cnt = 0;
  while (!s_axi_rvalid && cnt < AXI_TIMEOUT) begin
    @(negedge bus_clk);
    cnt++;
  end
  if (!s_axi_rvalid) begin
    $display("Timeout: read data for 0x%0h never arrived", addr);
    errors++;
  end
  data = s_axi_rdata;
  resp = s_axi_rresp;
  @(posedge bus_clk);
  @(negedge bus_clk);
endtask

`endif

/* tb/tb_e31x_ctrl.sv */
`timescale 1ns/1ps
// Testbench for the E31x front-end control top level
//   Clock, reset and watchdog
//   Register model and pin reference function
//   Directed and random tests with per-test summaries
module tb_e31x_ctrl;
  import e31x_ctrl_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int AXI_TIMEOUT = 100;
  // Rough per-test lengths in cycles
  localparam int TEST_CYCLES = 40 + 200 + 120 + 60 + 120 + 60;
  localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD + 20000;

  logic bus_clk, bus_rst;
  reg_addr_t s_axi_awaddr, s_axi_araddr;
  reg_data_t s_axi_wdata, s_axi_rdata;
  reg_strb_t s_axi_wstrb;
  axi_resp_t s_axi_bresp, s_axi_rresp;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
  logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
  logic s_axi_rvalid, s_axi_rready;
  logic onswitch_db, gps_pps, tx_pll_lock, rx_pll_lock;
  tcxo_status_t tcxo_status;
  logic press_irq, release_irq, pps_gpio;
  bandsel_wide_t tx_bandsel, rx1_bandsel, rx2_bandsel;
  bandsel_narrow_t rx1b_bandsel, rx1c_bandsel, rx2b_bandsel, rx2c_bandsel;
  logic tx_enable1a, tx_enable1b, tx_enable2a, tx_enable2b;
  logic vctxrx1_v1, vctxrx1_v2, vctxrx2_v1, vctxrx2_v2;
  logic vcrx1_v1, vcrx1_v2, vcrx2_v1, vcrx2_v2;
  logic led_txrx1_tx, led_txrx1_rx, led_rx1_rx;
  logic led_txrx2_tx, led_txrx2_rx, led_rx2_rx;

  int errors = 0;
  int checks = 0;
  int tests  = 0;
  int err_at_start = 0;
  integer seed = 32'h8607_f567;
  // Register model
  db_gpio_t m_gpio0, m_gpio1;
  led_t m_led0, m_led1;
  // Packed pins from the LEDs at bit 0 up to tx_bandsel at bit 34
  logic [34:0] exp_p, act_p;
  event compare_ev;

  `include "axil_bfm_tasks.svh"

  e31x_ctrl_top #(.IRQ_STRETCH(8)) dut (.*);

  assign act_p = {tx_bandsel, rx1_bandsel, rx2_bandsel,
                  rx1b_bandsel, rx1c_bandsel, rx2b_bandsel, rx2c_bandsel,
                  tx_enable1a, tx_enable1b, tx_enable2a, tx_enable2b,
                  vctxrx1_v1, vctxrx1_v2, vctxrx2_v1, vctxrx2_v2,
                  vcrx1_v1, vcrx1_v2, vcrx2_v1, vcrx2_v2,
                  led_txrx1_tx, led_txrx1_rx, led_rx1_rx,
                  led_txrx2_tx, led_txrx2_rx, led_rx2_rx};

  initial begin
    bus_clk = 1'b0;
    forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Register channel 1 feeds the channel-1 pins
  // Register channel 0 feeds the channel-2 pins
  function automatic logic [34:0] expected_pins(db_gpio_t g0, db_gpio_t g1,
                                                led_t l0, led_t l1);
    expected_pins = {g1[2:0] | g0[2:0], g1[5:3], g0[5:3],
                     g1[7:6], g1[9:8], g0[7:6], g0[9:8],
                     g1[10], g1[11], g0[10], g0[11],
                     g1[13], g1[12], g0[13], g0[12],
                     g1[15], g1[14], g0[15], g0[14],
                     l1[1], l1[0], l1[2], l0[1], l0[0], l0[2]};
  endfunction

  task automatic apply_write(reg_addr_t addr, reg_data_t data, reg_strb_t strb);
    case (addr)
      14'h0004: begin
        if (strb[0]) m_gpio0[7:0] = data[7:0];
        if (strb[1]) m_gpio0[15:8] = data[15:8];
      end
      14'h0008: begin
        if (strb[0]) m_gpio1[7:0] = data[7:0];
        if (strb[1]) m_gpio1[15:8] = data[15:8];
      end
      14'h000C: begin
        if (strb[0]) begin
          m_led0 = data[2:0];
          m_led1 = data[6:4];
        end
      end
      default: ;
    endcase
  endtask

  function automatic reg_data_t readback_value(reg_addr_t addr);
    case (addr)
      14'h0004: readback_value = {16'h0, m_gpio0};
      14'h0008: readback_value = {16'h0, m_gpio1};
      14'h000C: readback_value = {25'h0, m_led1, 1'b0, m_led0};
      default:  readback_value = 32'h0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] expv,
                           input logic [31:0] actv);
    checks++;
    if (expv !== actv) begin
      $display("Mismatch at %0t: %s expected 0x%0h actual 0x%0h",
               $time, name, expv, actv);
      errors++;
    end
  endtask

  task automatic compare_field(input string name, input int lsb, input int w);
    logic [31:0] e;
    logic [31:0] a;
    e = '0;
    a = '0;
    for (int i = 0; i < w; i++) begin
      e[i] = exp_p[lsb+i];
      a[i] = act_p[lsb+i];
    end
    check_val(name, e, a);
  endtask

  // Pin compare process
  always @(compare_ev) begin
    exp_p = expected_pins(m_gpio0, m_gpio1, m_led0, m_led1);
    compare_field("tx_bandsel", 32, 3);
    compare_field("rx1_bandsel", 29, 3);
    compare_field("rx2_bandsel", 26, 3);
    compare_field("rx1b_bandsel", 24, 2);
    compare_field("rx1c_bandsel", 22, 2);
    compare_field("rx2b_bandsel", 20, 2);
    compare_field("rx2c_bandsel", 18, 2);
    compare_field("tx_enable{1a,1b,2a,2b}", 14, 4);
    compare_field("vctxrx{1_v1,1_v2,2_v1,2_v2}", 10, 4);
    compare_field("vcrx{1_v1,1_v2,2_v1,2_v2}", 6, 4);
    compare_field("led{txrx1_tx,txrx1_rx,rx1_rx,txrx2_tx,txrx2_rx,rx2_rx}", 0, 6);
  end

  task automatic run_compare();
    -> compare_ev;
    #1;
  endtask

  task automatic check_read(input reg_addr_t addr, input reg_data_t expv);
    reg_data_t data;
    axi_resp_t resp;
    axil_read(addr, data, resp);
    check_val($sformatf("s_axi_rdata[0x%0h]", addr), expv, data);
    check_val("s_axi_rresp", 32'(RESP_OKAY), 32'(resp));
  endtask

  // Drives a switch level with an optional one-cycle glitch and checks both IRQs
  task automatic irq_pulse_check(input logic level, input bit glitch,
                                 input bit exp_press, input bit exp_rel);
    @(negedge bus_clk);
    onswitch_db = level;
    for (int k = 1; k <= 12; k++) begin
      @(negedge bus_clk);
      check_val("press_irq", 32'(exp_press && k <= 8), 32'(press_irq));
      check_val("release_irq", 32'(exp_rel && k <= 8), 32'(release_irq));
      if (k == 1 && glitch) onswitch_db = ~level;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - err_at_start);
    err_at_start = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    reg_addr_t addr;
    reg_data_t data;
    reg_strb_t strb;
    reg_data_t stat;
    axi_resp_t resp;
    logic pps_hist[$];
    s_axi_awaddr = '0;
    s_axi_araddr = '0;
    s_axi_wdata = '0;
    s_axi_wstrb = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_bready = 1'b1;
    s_axi_rready = 1'b1;
    onswitch_db = 1'b1;
    gps_pps = 1'b0;
    tcxo_status = '0;
    tx_pll_lock = 1'b0;
    rx_pll_lock = 1'b0;
    m_gpio0 = '0;
    m_gpio1 = '0;
    m_led0 = '0;
    m_led1 = '0;
    bus_rst = 1'b1;
    repeat (3) @(posedge bus_clk);
    @(negedge bus_clk);
    bus_rst = 1'b0;

    // Reset state
    // Switch held high must not raise a release
    repeat (3) @(negedge bus_clk);
    run_compare();
    check_val("press_irq", 32'h0, 32'(press_irq));
    check_val("release_irq", 32'h0, 32'(release_irq));
    check_val("pps_gpio", 32'h0, 32'(pps_gpio));
    check_read(REG_DB_GPIO0, 32'h0);
    check_read(REG_DB_GPIO1, 32'h0);
    check_read(REG_LEDS, 32'h0);
    end_test("reset state");

    // Random words with random strobes on every other one
    for (int i = 0; i < 12; i++) begin
      r = $random(seed);
      case (r % 3)
        0:       addr = REG_DB_GPIO0;
        1:       addr = REG_DB_GPIO1;
        default: addr = REG_LEDS;
      endcase
      data = $random(seed);
      r = $random(seed);
      strb = (i % 2 == 0) ? 4'hF : r[3:0];
      axil_write(addr, data, strb, resp);
      apply_write(addr, data, strb);
      check_val("s_axi_bresp", 32'(RESP_OKAY), 32'(resp));
      run_compare();
      check_read(addr, readback_value(addr));
    end
    end_test("pin mapping");

    // Status word from held inputs
    for (int i = 0; i < 4; i++) begin
      @(negedge bus_clk);
      r = $random(seed);
      tcxo_status = r[3:0];
      tx_pll_lock = r[4];
      rx_pll_lock = r[5];
      // Read address taken on the edge right after the two sync edges
      repeat (1) @(negedge bus_clk);
      stat = '0;
      stat[13:10] = r[3:0];
      stat[9] = r[4];
      stat[8] = r[5];
      check_read(REG_DB_STATUS, stat);
    end
    axil_write(REG_DB_STATUS, 32'hFFFF_FFFF, 4'hF, resp);
    check_val("s_axi_bresp", 32'(RESP_OKAY), 32'(resp));
    check_read(REG_DB_STATUS, stat);
    axil_write(14'h0020, 32'hFFFF_FFFF, 4'hF, resp);
    check_val("s_axi_bresp", 32'(RESP_OKAY), 32'(resp));
    run_compare();
    check_read(14'h0010, 32'h0);
    check_read(14'h1FFC, 32'h0);
    end_test("status read-back");

    // Second write stalls while the first response is held
    @(negedge bus_clk);
    s_axi_bready = 1'b0;
    write_issue(REG_DB_GPIO0, 32'h0000_A5C3, 4'hF);
    apply_write(REG_DB_GPIO0, 32'h0000_A5C3, 4'hF);
    run_compare();
    s_axi_awaddr = REG_DB_GPIO0;
    s_axi_wdata = 32'h0000_3C5A;
    s_axi_wstrb = 4'hF;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid = 1'b1;
    for (int k = 0; k < 4; k++) begin
      #1;
      check_val("s_axi_awready", 32'h0, 32'(s_axi_awready));
      check_val("s_axi_wready", 32'h0, 32'(s_axi_wready));
      check_val("s_axi_bvalid", 32'h1, 32'(s_axi_bvalid));
      @(negedge bus_clk);
    end
    run_compare();
    s_axi_bready = 1'b1;
    write_issue(REG_DB_GPIO0, 32'h0000_3C5A, 4'hF);
    write_resp(resp);
    check_val("s_axi_bresp", 32'(RESP_OKAY), 32'(resp));
    apply_write(REG_DB_GPIO0, 32'h0000_3C5A, 4'hF);
    run_compare();
    check_read(REG_DB_GPIO0, readback_value(REG_DB_GPIO0));
    end_test("back-pressure");

    // Press, release, then single-cycle glitches both ways
    repeat (4) @(negedge bus_clk);
    irq_pulse_check(1'b0, 1'b0, 1'b1, 1'b0);
    irq_pulse_check(1'b1, 1'b0, 1'b0, 1'b1);
    irq_pulse_check(1'b0, 1'b1, 1'b1, 1'b0);
    irq_pulse_check(1'b0, 1'b0, 1'b1, 1'b0);
    irq_pulse_check(1'b1, 1'b1, 1'b0, 1'b1);
    irq_pulse_check(1'b1, 1'b0, 1'b0, 1'b1);
    end_test("button interrupts");

    // Three-edge PPS copy
    // History starts from the idle low input
    repeat (3) pps_hist.push_back(1'b0);
    for (int j = 0; j < 40; j++) begin
      @(negedge bus_clk);
      check_val("pps_gpio", 32'(pps_hist.pop_front()), 32'(pps_gpio));
      r = $random(seed);
      gps_pps = r[0];
      pps_hist.push_back(r[0]);
    end
    end_test("PPS copy");

    $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+tb
verilog/e31x_ctrl_pkg.sv
verilog/axil_ctrl_regs.sv
verilog/status_sync.sv
verilog/button_irq.sv
verilog/fe_pin_map.sv
verilog/e31x_ctrl_top.sv
tb/tb_e31x_ctrl.sv

/* Makefile */
# Verilator simulation of the E31x front-end control block

VERILATOR ?= verilator
TOP       ?= tb_e31x_ctrl
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
